// ==== src/issuer_consts.svh ====
// sizing macros for the command issuer, included by the package and any module needing widths
`ifndef ISSUER_CONSTS_SVH
`define ISSUER_CONSTS_SVH

// processors in the SIMD array
`define ISS_PROC_COUNT 4

// slots for parked commands, power of two
`define ISS_FIFO_DEPTH 8

// command and dependency id width, id 0 means none
`define ISS_ID_W 6

`define ISS_ADDR_W 12   // load/store address
`define ISS_COUNT_W 8   // element count in the info word
`define ISS_OP_W 4      // processor op code

// count and op share the info operand, so together they fill one address field

`endif

// ==== src/issuer_pkg.sv ====
// types and helpers shared by the issuer modules and testbench, use with import issuer_pkg::*
`default_nettype none
`include "issuer_consts.svh"

package issuer_pkg;

    typedef logic [`ISS_ID_W-1:0] cmd_id_t;

    // payload of one command
    typedef struct packed {
        logic [`ISS_ADDR_W-1:0]  addr_0;
        logic [`ISS_ADDR_W-1:0]  addr_1;
        logic [`ISS_ADDR_W-1:0]  wr_addr;
        logic [`ISS_COUNT_W-1:0] count;
        logic [`ISS_OP_W-1:0]    op;
    } cmd_info_t;

    // one queue entry
    typedef struct packed {
        cmd_id_t   id;
        cmd_id_t   dep;   // 0 when free to run
        cmd_info_t info;
    } cmd_t;

    typedef logic [$clog2(`ISS_PROC_COUNT)-1:0] proc_idx_t;
    typedef logic [`ISS_PROC_COUNT-1:0]         proc_mask_t;

    typedef enum logic [1:0] {INSTR_NOP, INSTR_LD, INSTR_INFO, INSTR_STORE} instr_op_e;

    // info operand is {count, op}
    typedef struct packed {
        instr_op_e              opcode;
        logic [`ISS_ADDR_W-1:0] operand;
    } instr_t;

    typedef enum logic [2:0] {
        ISS_IDLE, ISS_FINISH, ISS_FETCH, ISS_CHECK, ISS_PARK, ISS_ISSUE
    } issue_state_e;

    typedef enum logic [2:0] {
        SND_IDLE, SND_SELECT, SND_LD0, SND_LD1, SND_INFO, SND_STORE
    } send_state_e;

    // index of the lowest set bit, 0 for an empty mask
    function automatic proc_idx_t lowest_set(input proc_mask_t mask);
        proc_idx_t idx;
        idx = '0;
        for (int i = `ISS_PROC_COUNT - 1; i >= 0; i--) begin
            if (mask[i]) idx = proc_idx_t'(i);
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// ==== src/dep_fifo.sv ====
// circular buffer parking commands whose dependency is still running, head visible without a pop
`timescale 1ns/1ns
`default_nettype none
`include "issuer_consts.svh"

module dep_fifo #(
    parameter int DEPTH = `ISS_FIFO_DEPTH
) (
    input  wire                    i_clk,
    input  wire                    i_rstn,
    input  wire                    i_push,
    input  wire                    i_pop,
    input  wire issuer_pkg::cmd_t  i_data,
    output issuer_pkg::cmd_t       o_data,
    output logic                   o_empty,
    output logic                   o_full,
    output logic [$clog2(DEPTH):0] o_count
);
    import issuer_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    cmd_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign o_empty = (o_count == '0);
    assign o_full  = (o_count == (PTR_W + 1)'(DEPTH));

    // ignore push when full and pop when empty
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_data = mem[rd_ptr]; // head shows through

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count; // both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) mem[wr_ptr] <= i_data;
    end

endmodule

`default_nettype wire

// ==== src/inflight_table.sv ====
// record of the command id running on each processor, searched in parallel for dependencies
`timescale 1ns/1ns
`default_nettype none

module inflight_table (
    input  wire                        i_clk,
    input  wire                        i_rstn,
    input  wire                        i_set,
    input  wire                        i_clear,
    input  wire issuer_pkg::proc_idx_t i_set_proc,
    input  wire issuer_pkg::proc_idx_t i_clear_proc,
    input  wire issuer_pkg::cmd_id_t   i_set_id,
    input  wire issuer_pkg::cmd_id_t   i_lookup_id,
    output logic                       o_hit
);
    import issuer_pkg::*;

    localparam int N = $bits(proc_mask_t);

    proc_mask_t valid;        // entry holds a running command
    cmd_id_t    run_id [N];
    proc_mask_t match;

    // valid bits
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            valid <= '0;
        end else begin
            if (i_clear) begin
                valid[i_clear_proc] <= 1'b0;
            end
            if (i_set) begin
                valid[i_set_proc] <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_set) run_id[i_set_proc] <= i_set_id;
    end

    // one comparator per processor
    // ids are never 0, so a lookup of 0 cannot hit
    always_comb begin
        for (int i = 0; i < N; i++) begin
            match[i] = valid[i] && (run_id[i] == i_lookup_id);
        end
    end

    assign o_hit = |match;

endmodule

`default_nettype wire

// ==== src/issue_ctrl.sv ====
// issuer FSM serving finishes, rescanning parked commands and fetching new ones from the queue
`timescale 1ns/1ns
`default_nettype none
`include "issuer_consts.svh"

module issue_ctrl (
    input  wire                                i_clk,
    input  wire                                i_rstn,
    input  wire issuer_pkg::cmd_t              i_cmd,
    input  wire                                i_queue_empty,
    input  wire issuer_pkg::proc_mask_t        i_busy_proc,
    input  wire issuer_pkg::proc_mask_t        i_finish_proc,
    input  wire issuer_pkg::cmd_t              fifo_data,
    input  wire                                fifo_empty,
    input  wire                                fifo_full,
    input  wire [$clog2(`ISS_FIFO_DEPTH):0]    fifo_count,
    input  wire                                table_hit,
    input  wire                                send_done,
    output logic                               o_queue_rd,
    output issuer_pkg::proc_mask_t             o_ack_proc,
    output logic                               fifo_push,
    output logic                               fifo_pop,
    output issuer_pkg::cmd_t                   fifo_wdata,
    output logic                               table_set,
    output logic                               table_clear,
    output issuer_pkg::proc_idx_t              table_set_proc,
    output issuer_pkg::proc_idx_t              table_clear_proc,
    output issuer_pkg::cmd_id_t                table_set_id,
    output issuer_pkg::cmd_id_t                table_lookup_id,
    output logic                               send_start,
    output issuer_pkg::proc_idx_t              send_proc,
    output issuer_pkg::cmd_info_t              send_info
);
    import issuer_pkg::*;

    localparam int CNT_W = $clog2(`ISS_FIFO_DEPTH) + 1;

    issue_state_e     state;
    cmd_t             cur_cmd;   // command in flight through the FSM
    proc_idx_t        fin_proc;  // processor being acked
    logic             from_fifo; // fetch source
    logic             started;   // start already sent in ISSUE
    logic [CNT_W-1:0] budget;    // parked commands left to rescan
    logic             any_free;

    assign any_free = ~&i_busy_proc;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state     <= ISS_IDLE;
            fin_proc  <= '0;
            from_fifo <= 1'b0;
            started   <= 1'b0;
            budget    <= '0;
        end else begin
            case (state)
                ISS_IDLE: begin
                    if (|i_finish_proc) begin
                        fin_proc <= lowest_set(i_finish_proc);
                        state    <= ISS_FINISH;
                    end else if (budget != '0 && !fifo_empty && any_free) begin
                        from_fifo <= 1'b1;
                        state     <= ISS_FETCH;
                    end else if (!i_queue_empty && any_free && !fifo_full) begin
                        from_fifo <= 1'b0;
                        state     <= ISS_FETCH;
                    end
                end
                ISS_FINISH: begin
                    budget <= fifo_count; // give every parked command one more look
                    state  <= ISS_IDLE;
                end
                ISS_FETCH: begin
                    if (from_fifo) budget <= budget - 1'b1;
                    state <= ISS_CHECK;
                end
                ISS_CHECK: begin
                    state <= table_hit ? ISS_PARK : ISS_ISSUE;
                end
                ISS_PARK: begin
                    state <= ISS_IDLE;
                end
                ISS_ISSUE: begin
                    started <= 1'b1;
                    if (send_done) begin
                        started <= 1'b0;
                        state   <= ISS_IDLE;
                    end
                end
                default: state <= ISS_IDLE;
            endcase
        end
    end

    // command register, loaded from whichever source was picked
    always_ff @(posedge i_clk) begin
        if (state == ISS_FETCH) begin
            cur_cmd <= from_fifo ? fifo_data : i_cmd;
        end
    end

    assign o_queue_rd = (state == ISS_FETCH) && !from_fifo;
    assign fifo_pop   = (state == ISS_FETCH) && from_fifo;
    assign fifo_push  = (state == ISS_PARK);
    assign fifo_wdata = cur_cmd;

    // finish handling
    assign table_clear      = (state == ISS_FINISH);
    assign table_clear_proc = fin_proc;

    always_comb begin
        o_ack_proc = '0;
        if (state == ISS_FINISH) o_ack_proc[fin_proc] = 1'b1;
    end

    assign table_lookup_id = cur_cmd.dep;

    // busy bits only fall on a finish ack, so the free pick holds until start
    assign send_start     = (state == ISS_ISSUE) && !started;
    assign send_proc      = lowest_set(~i_busy_proc);
    assign send_info      = cur_cmd.info;
    assign table_set      = send_start;
    assign table_set_proc = send_proc;
    assign table_set_id   = cur_cmd.id;

endmodule

`default_nettype wire

// ==== src/instr_sender.sv ====
// sequencer that enables one processor and walks it through the four instruction words
`timescale 1ns/1ns
`default_nettype none

module instr_sender (
    input  wire                         i_clk,
    input  wire                         i_rstn,
    input  wire                         i_start,
    input  wire issuer_pkg::proc_idx_t  i_proc,
    input  wire issuer_pkg::cmd_info_t  i_info,
    input  wire issuer_pkg::proc_mask_t i_busy_proc,
    input  wire issuer_pkg::proc_mask_t i_ack_proc,
    output issuer_pkg::proc_mask_t      o_en_proc,
    output issuer_pkg::instr_t          o_instr,
    output logic                        o_done
);
    import issuer_pkg::*;

    send_state_e state;
    proc_idx_t   proc_q;  // target processor
    cmd_info_t   info_q;
    logic        ack_sel;
    logic        busy_sel;

    assign ack_sel  = i_ack_proc[proc_q];
    assign busy_sel = i_busy_proc[proc_q];

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state <= SND_IDLE;
        end else begin
            case (state)
                SND_IDLE:   if (i_start) state <= SND_SELECT;
                SND_SELECT: if (!busy_sel) state <= SND_LD0; // enable pulsed here
                SND_LD0:    if (ack_sel) state <= SND_LD1;
                SND_LD1:    if (ack_sel) state <= SND_INFO;
                SND_INFO:   if (ack_sel) state <= SND_STORE;
                SND_STORE:  if (ack_sel) state <= SND_IDLE;
                default:    state <= SND_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == SND_IDLE && i_start) begin
            proc_q <= i_proc;
            info_q <= i_info;
        end
    end

    always_comb begin
        o_en_proc = '0;
        if (state == SND_SELECT && !busy_sel) o_en_proc[proc_q] = 1'b1;
    end

    // word on the bus, NOP outside the word states
    always_comb begin
        o_instr = '0;
        case (state)
            SND_LD0: begin
                o_instr.opcode  = INSTR_LD;
                o_instr.operand = info_q.addr_0;
            end
            SND_LD1: begin
                o_instr.opcode  = INSTR_LD;
                o_instr.operand = info_q.addr_1;
            end
            SND_INFO: begin
                o_instr.opcode  = INSTR_INFO;
                o_instr.operand = {info_q.count, info_q.op};
            end
            SND_STORE: begin
                o_instr.opcode  = INSTR_STORE;
                o_instr.operand = info_q.wr_addr;
            end
            default: o_instr = '0;
        endcase
    end

    assign o_done = (state == SND_STORE) && ack_sel; // last word taken

endmodule

`default_nettype wire

// ==== src/issuer_top.sv ====
// top level of the command issuer, connects the queue and processor ports to the internal blocks
`timescale 1ns/1ns
`default_nettype none
`include "issuer_consts.svh"

module issuer_top (
    input  wire                         i_clk,
    input  wire                         i_rstn,
    input  wire issuer_pkg::cmd_t       i_cmd,
    input  wire                         i_queue_empty,
    input  wire issuer_pkg::proc_mask_t i_busy_proc,
    input  wire issuer_pkg::proc_mask_t i_finish_proc,
    input  wire issuer_pkg::proc_mask_t i_ack_proc,
    output logic                        o_queue_rd,
    output issuer_pkg::proc_mask_t      o_en_proc,
    output issuer_pkg::instr_t          o_instr,
    output issuer_pkg::proc_mask_t      o_ack_proc
);
    import issuer_pkg::*;

    // parked-command FIFO
    logic                              fifo_push;
    logic                              fifo_pop;
    cmd_t                              fifo_wdata;
    cmd_t                              fifo_data;
    logic                              fifo_empty;
    logic                              fifo_full;
    logic [$clog2(`ISS_FIFO_DEPTH):0]  fifo_count;

    // in-flight table
    logic      table_set;
    logic      table_clear;
    proc_idx_t table_set_proc;
    proc_idx_t table_clear_proc;
    cmd_id_t   table_set_id;
    cmd_id_t   table_lookup_id;
    logic      table_hit;

    // controller to sender
    logic      send_start;
    proc_idx_t send_proc;
    cmd_info_t send_info;
    logic      send_done;

    issue_ctrl u_ctrl (
        .i_clk            (i_clk),
        .i_rstn           (i_rstn),
        .i_cmd            (i_cmd),
        .i_queue_empty    (i_queue_empty),
        .i_busy_proc      (i_busy_proc),
        .i_finish_proc    (i_finish_proc),
        .fifo_data        (fifo_data),
        .fifo_empty       (fifo_empty),
        .fifo_full        (fifo_full),
        .fifo_count       (fifo_count),
        .table_hit        (table_hit),
        .send_done        (send_done),
        .o_queue_rd       (o_queue_rd),
        .o_ack_proc       (o_ack_proc),
        .fifo_push        (fifo_push),
        .fifo_pop         (fifo_pop),
        .fifo_wdata       (fifo_wdata),
        .table_set        (table_set),
        .table_clear      (table_clear),
        .table_set_proc   (table_set_proc),
        .table_clear_proc (table_clear_proc),
        .table_set_id     (table_set_id),
        .table_lookup_id  (table_lookup_id),
        .send_start       (send_start),
        .send_proc        (send_proc),
        .send_info        (send_info)
    );

    instr_sender u_sender (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_start     (send_start),
        .i_proc      (send_proc),
        .i_info      (send_info),
        .i_busy_proc (i_busy_proc),
        .i_ack_proc  (i_ack_proc),
        .o_en_proc   (o_en_proc),
        .o_instr     (o_instr),
        .o_done      (send_done)
    );

    inflight_table u_table (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_set        (table_set),
        .i_clear      (table_clear),
        .i_set_proc   (table_set_proc),
        .i_clear_proc (table_clear_proc),
        .i_set_id     (table_set_id),
        .i_lookup_id  (table_lookup_id),
        .o_hit        (table_hit)
    );

    dep_fifo #(
        .DEPTH (`ISS_FIFO_DEPTH)
    ) u_fifo (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_push  (fifo_push),
        .i_pop   (fifo_pop),
        .i_data  (fifo_wdata),
        .o_data  (fifo_data),
        .o_empty (fifo_empty),
        .o_full  (fifo_full),
        .o_count (fifo_count)
    );

endmodule

`default_nettype wire

// ==== sim/issuer_tb.sv ====
// self-checking testbench for issuer_top with a queue model, processor models and a word checker
`timescale 1ns/1ns
`default_nettype none
`include "issuer_consts.svh"

module issuer_tb;
    import issuer_pkg::*;

    localparam int NPROC     = $bits(proc_mask_t);
    localparam int NCMD      = 40;
    localparam int POOL      = 1024;
    localparam int ACK_LIMIT = 400;    // cycles a finish may wait for its ack
    localparam int RUN_LIMIT = 20000;  // cycles for the whole run

    typedef enum logic [1:0] {P_IDLE, P_WORDS, P_RUN, P_FIN} proc_state_e;

    logic       i_clk;
    logic       i_rstn;
    cmd_t       i_cmd;
    logic       i_queue_empty;
    proc_mask_t i_busy_proc;
    proc_mask_t i_finish_proc;
    proc_mask_t i_ack_proc;
    logic       o_queue_rd;
    proc_mask_t o_en_proc;
    instr_t     o_instr;
    proc_mask_t o_ack_proc;

    cmd_t        cmds [0:NCMD];      // index is the command id
    int          run_len [0:NCMD];
    int unsigned rand_pool [POOL];
    int          rand_idx;
    int          qhead;              // id at the queue head

    proc_state_e pst [NPROC];
    int          pword [NPROC];
    int          pdly [NPROC];
    cmd_id_t     pcmd [NPROC];

    // scoreboard
    logic       fetched [0:NCMD];
    logic       issued [0:NCMD];
    int         next_free;          // id the next issue must carry or 0
    logic       run_valid [NPROC];
    int         run_id [NPROC];
    int         ack_count;
    proc_mask_t fin_prev;

    issuer_top UUT (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_cmd         (i_cmd),
        .i_queue_empty (i_queue_empty),
        .i_busy_proc   (i_busy_proc),
        .i_finish_proc (i_finish_proc),
        .i_ack_proc    (i_ack_proc),
        .o_queue_rd    (o_queue_rd),
        .o_en_proc     (o_en_proc),
        .o_instr       (o_instr),
        .o_ack_proc    (o_ack_proc)
    );

    always #2 i_clk = ~i_clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %0h expected %0h",
                                     $time, name, got, exp));
        end
    endtask

    // four words a command should produce, in order
    function automatic instr_t expected_word(input cmd_t c, input int n);
        instr_t w;
        w = '0;
        case (n)
            0: begin
                w.opcode  = INSTR_LD;
                w.operand = c.info.addr_0;
            end
            1: begin
                w.opcode  = INSTR_LD;
                w.operand = c.info.addr_1;
            end
            2: begin
                w.opcode  = INSTR_INFO;
                w.operand = {c.info.count, c.info.op};
            end
            default: begin
                w.opcode  = INSTR_STORE;
                w.operand = c.info.wr_addr;
            end
        endcase
        return w;
    endfunction

    function automatic proc_mask_t lowest_bit(input proc_mask_t m);
        proc_mask_t r;
        r = '0;
        for (int i = NPROC - 1; i >= 0; i--) begin
            if (m[i]) r = proc_mask_t'(1) << i;
        end
        return r;
    endfunction

    // ack delay of 0 to 3 cycles from the seeded pool
    function automatic int next_delay();
        int d;
        d = int'(rand_pool[rand_idx % POOL] % 4);
        rand_idx = rand_idx + 1;
        return d;
    endfunction

    // queue model with first word fall-through
    always @(posedge i_clk) begin
        if (i_rstn && o_queue_rd) begin
            qhead <= qhead + 1;
            if (qhead < NCMD) i_cmd <= cmds[qhead + 1];
            i_queue_empty <= (qhead >= NCMD);
        end
    end

    // processor models
    always @(posedge i_clk) begin
        int d;
        if (i_rstn) begin
            for (int p = 0; p < NPROC; p++) begin
                if (o_en_proc[p] && pst[p] != P_IDLE)
                    report_failure($sformatf("enable sent to busy processor %0d", p));
                if (o_ack_proc[p] && pst[p] != P_FIN)
                    report_failure($sformatf(
                        "finish ack sent to processor %0d, which did not finish", p));
                case (pst[p])
                    P_IDLE: if (o_en_proc[p]) begin
                        d = next_delay();
                        i_busy_proc[p] <= 1'b1;
                        i_ack_proc[p]  <= (d == 0);
                        pdly[p]  <= d;
                        pword[p] <= 0;
                        pst[p]   <= P_WORDS;
                    end
                    P_WORDS: if (i_ack_proc[p]) begin  // word taken at this edge
                        if (pword[p] == 0) pcmd[p] <= cmd_id_t'(o_instr.operand);
                        if (pword[p] == 3) begin
                            i_ack_proc[p] <= 1'b0;
                            pdly[p] <= run_len[pcmd[p]];
                            pst[p]  <= P_RUN;
                        end else begin
                            d = next_delay();
                            i_ack_proc[p] <= (d == 0);
                            pdly[p]  <= d;
                            pword[p] <= pword[p] + 1;
                        end
                    end else begin
                        pdly[p] <= pdly[p] - 1;
                        if (pdly[p] == 1) i_ack_proc[p] <= 1'b1;
                    end
                    P_RUN: if (pdly[p] <= 1) begin
                        i_finish_proc[p] <= 1'b1;
                        pdly[p] <= 0;
                        pst[p]  <= P_FIN;
                    end else begin
                        pdly[p] <= pdly[p] - 1;
                    end
                    default: if (o_ack_proc[p]) begin
                        i_finish_proc[p] <= 1'b0;
                        i_busy_proc[p]   <= 1'b0;
                        pst[p] <= P_IDLE;
                    end else if (pdly[p] > ACK_LIMIT) begin
                        report_failure($sformatf("timeout: finish of processor %0d never acked", p));
                    end else begin
                        pdly[p] <= pdly[p] + 1;
                    end
                endcase
            end
        end
    end

    // comparing process
    always @(posedge i_clk) begin
        int id;
        int dep;
        logic blocked;
        if (i_rstn) begin
            if (|o_ack_proc) begin
                check_value("o_ack_proc", o_ack_proc, lowest_bit(fin_prev));
                for (int p = 0; p < NPROC; p++) begin
                    if (o_ack_proc[p]) run_valid[p] = 1'b0;
                end
                ack_count = ack_count + 1;
            end
            if (|o_en_proc) check_value("o_en_proc", o_en_proc, lowest_bit(~i_busy_proc));
            if (o_queue_rd) begin
                if (qhead > NCMD) report_failure("queue read while the queue was empty");
                fetched[qhead] = 1'b1;
                dep = int'(cmds[qhead].dep);
                blocked = 1'b0;
                for (int r = 0; r < NPROC; r++) begin
                    if (dep != 0 && run_valid[r] && run_id[r] == dep) blocked = 1'b1;
                end
                next_free = blocked ? 0 : qhead;  // a free command goes out straight away
            end
            for (int q = 0; q < NPROC; q++) begin
                if (i_ack_proc[q] && pst[q] == P_WORDS) begin
                    if (pword[q] == 0) begin
                        id = int'(o_instr.operand);
                        if (id < 1 || id > NCMD || !fetched[id])
                            report_failure($sformatf(
                                "words sent for command %0d, never read from the queue", id));
                        if (issued[id])
                            report_failure($sformatf("command %0d issued twice", id));
                        if (next_free != 0)
                            check_value("issued command id", id, next_free);
                        next_free = 0;
                        dep = int'(cmds[id].dep);
                        for (int r = 0; r < NPROC; r++) begin
                            if (dep != 0 && run_valid[r] && run_id[r] == dep)
                                report_failure($sformatf(
                                    "command %0d issued while %0d still runs", id, dep));
                        end
                        issued[id]   = 1'b1;
                        run_valid[q] = 1'b1;
                        run_id[q]    = id;
                    end
                    check_value("o_instr", o_instr, expected_word(cmds[run_id[q]], pword[q]));
                end
            end
            fin_prev = i_finish_proc;
        end
    end

    initial begin
        int  waited;
        logic ok;
        void'($urandom(32'h8d90_8ec4));
        for (int i = 0; i < POOL; i++) rand_pool[i] = $urandom;
        rand_idx = 0;
        cmds[0] = '0;
        run_len[0] = 1;
        for (int i = 1; i <= NCMD; i++) begin
            cmds[i].id           = cmd_id_t'(i);
            cmds[i].info.addr_0  = `ISS_ADDR_W'(i);  // ties a word stream to its command
            cmds[i].info.addr_1  = `ISS_ADDR_W'($urandom);
            cmds[i].info.wr_addr = `ISS_ADDR_W'($urandom);
            cmds[i].info.count   = `ISS_COUNT_W'($urandom);
            cmds[i].info.op      = `ISS_OP_W'($urandom);
            if (i == 1) begin
                cmds[i].dep = '0;
                run_len[i]  = 150;  // long runner that makes everything behind it park
            end else if (i <= 11) begin
                cmds[i].dep = cmd_id_t'(1);
                run_len[i]  = 1 + $urandom % 8;
            end else begin
                cmds[i].dep = ($urandom % 2) ? cmd_id_t'(i - 1 - $urandom % 3) : '0;
                run_len[i]  = 1 + $urandom % 24;
            end
        end
        for (int i = 0; i <= NCMD; i++) begin
            fetched[i] = 1'b0;
            issued[i]  = 1'b0;
        end
        for (int p = 0; p < NPROC; p++) begin
            pst[p]       = P_IDLE;
            pword[p]     = 0;
            pdly[p]      = 0;
            pcmd[p]      = '0;
            run_valid[p] = 1'b0;
            run_id[p]    = 0;
        end
        next_free = 0;
        ack_count = 0;
        fin_prev  = '0;
        qhead     = 1;
        i_clk = 1'b0;
        i_rstn        <= 1'b0;
        i_cmd         <= cmds[1];
        i_queue_empty <= 1'b0;
        i_busy_proc   <= '0;
        i_finish_proc <= '0;
        i_ack_proc    <= '0;
        repeat (15) @(posedge i_clk);
        @(negedge i_clk);
        check_value("o_queue_rd", o_queue_rd, 0);
        check_value("o_en_proc", o_en_proc, 0);
        check_value("o_ack_proc", o_ack_proc, 0);
        check_value("o_instr", o_instr, 0);
        @(posedge i_clk);
        i_rstn <= 1'b1;
        waited = 0;
        while (ack_count < NCMD) begin
            @(negedge i_clk);
            waited = waited + 1;
            if (waited > RUN_LIMIT)
                report_failure($sformatf("timeout: %0d of %0d commands finished", ack_count, NCMD));
        end
        check_value("o_instr", o_instr, 0);  // NOP once the last STORE is taken
        ok = (qhead == NCMD + 1);
        for (int i = 1; i <= NCMD; i++) ok = ok && issued[i];
        if (ok) begin
            $display("Verification passed");
            $finish;
        end else begin
            report_failure("not every queued command was read and issued");
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/issuer_pkg.sv
src/dep_fifo.sv
src/inflight_table.sv
src/issue_ctrl.sv
src/instr_sender.sv
src/issuer_top.sv
sim/issuer_tb.sv
